//--- hello_world_pkg.sv
package hello_world_pkg;

  // --------------------------------------------------
  // Control bus geometry
  // --------------------------------------------------
  localparam int bus_data_w = 32;
  localparam int bus_addr_w = 32;

  // OKAY response on both write and read channels
  localparam logic [1:0] resp_okay = 2'b00;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam logic [bus_addr_w-1:0] hello_world_addr = 32'h0000_0500;
  localparam logic [bus_addr_w-1:0] vled_addr        = 32'h0000_0504;
  localparam logic [bus_addr_w-1:0] cnt_ctrl_addr    = 32'h0000_0508;
  localparam logic [bus_addr_w-1:0] cnt_load_addr    = 32'h0000_050C;
  localparam logic [bus_addr_w-1:0] cnt_wmark_addr   = 32'h0000_0510;
  // Read-only, writes are dropped
  localparam logic [bus_addr_w-1:0] cnt_status_addr  = 32'h0000_0514;

  // --------------------------------------------------
  // Counter control word
  // --------------------------------------------------
  // Field layout, MSB first
  typedef struct packed {
    logic [19:0] rsvd;
    logic        enable;
    logic        load;
    logic        clear;
    logic        oneshot;
    logic [7:0]  tick_value;
  } cnt_ctrl_fields_t;

  // Bus side sees raw, counter side sees fields
  typedef union packed {
    logic [bus_data_w-1:0] raw;
    cnt_ctrl_fields_t      fields;
  } cnt_ctrl_u;

endpackage

//--- ocl_bus_slave.sv
module ocl_bus_slave (
  input  logic                                   clk_main_a0,
  input  logic                                   rst_main_n_sync,
  // Write address channel
  input  logic                                   awvalid,
  input  logic [hello_world_pkg::bus_addr_w-1:0] awaddr,
  output logic                                   awready,
  // Write data channel
  input  logic                                   wvalid,
  input  logic [hello_world_pkg::bus_data_w-1:0] wdata,
  output logic                                   wready,
  // Write response channel
  output logic                                   bvalid,
  output logic [1:0]                             bresp,
  input  logic                                   bready,
  // Read address channel
  input  logic                                   arvalid,
  input  logic [hello_world_pkg::bus_addr_w-1:0] araddr,
  output logic                                   arready,
  // Read data channel
  output logic                                   rvalid,
  output logic [hello_world_pkg::bus_data_w-1:0] rdata,
  output logic [1:0]                             rresp,
  input  logic                                   rready,
  // Register file side
  output logic                                   wr_en,
  output logic [hello_world_pkg::bus_addr_w-1:0] wr_addr,
  output logic [hello_world_pkg::bus_data_w-1:0] wr_data,
  output logic [hello_world_pkg::bus_addr_w-1:0] rd_addr,
  input  logic [hello_world_pkg::bus_data_w-1:0] rd_data
);
  import hello_world_pkg::*;

  logic wr_active;
  logic ar_pend;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  // One write in flight, address first then data
  assign awready = ~wr_active;
  // Data accepted once per write, blocked while response waits
  assign wready  = wr_active & wvalid & ~bvalid;
  // Strobe lines up with the data transfer
  assign wr_en   = wready;
  assign wr_data = wdata;
  assign bresp   = resp_okay;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end
    else
    begin
      // Busy from address accept until response taken
      if (awvalid && awready)
        wr_active <= 1'b1;
      else if (bvalid && bready)
        wr_active <= 1'b0;
      // Response follows the data beat
      if (wready)
        bvalid <= 1'b1;
      else if (bvalid && bready)
        bvalid <= 1'b0;
    end
  end

  // Captured write address
  always_ff @(posedge clk_main_a0)
  begin
    if (awvalid && awready)
      wr_addr <= awaddr;
  end

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  // No new read until the previous one is consumed
  assign arready = ~ar_pend & ~rvalid;
  assign rresp   = resp_okay;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      ar_pend <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      ar_pend <= arvalid && arready;
      // Pending request turns into valid read data
      if (ar_pend)
        rvalid <= 1'b1;
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  // Address and data payload, held until the next request
  always_ff @(posedge clk_main_a0)
  begin
    if (arvalid && arready)
      rd_addr <= araddr;
    if (ar_pend)
      rdata <= rd_data;
  end

endmodule

//--- hello_world_regs.sv
module hello_world_regs #(
  parameter int cnt_w  = 16,
  parameter int tick_w = 8,
  parameter int led_w  = 16
) (
  input  logic                                   clk_main_a0,
  input  logic                                   rst_main_n_sync,
  // Bus side
  input  logic                                   wr_en,
  input  logic [hello_world_pkg::bus_addr_w-1:0] wr_addr,
  input  logic [hello_world_pkg::bus_data_w-1:0] wr_data,
  input  logic [hello_world_pkg::bus_addr_w-1:0] rd_addr,
  output logic [hello_world_pkg::bus_data_w-1:0] rd_data,
  // Counter control and status
  output hello_world_pkg::cnt_ctrl_u             ctrl,
  output logic [cnt_w-1:0]                       load_value,
  output logic [cnt_w-1:0]                       watermark,
  input  logic [cnt_w-1:0]                       cnt,
  input  logic [tick_w-1:0]                      tick_cnt,
  input  logic                                   tick,
  input  logic                                   ge_watermark,
  // LED stage
  output logic [led_w-1:0]                       led_shadow,
  input  logic [led_w-1:0]                       led_status
);
  import hello_world_pkg::*;

  logic [bus_data_w-1:0] hello_world_q;
  logic [bus_data_w-1:0] hello_world_swap;
  logic [bus_data_w-1:0] status_word;

  // --------------------------------------------------
  // Writable registers
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello_world_q <= '0;
      ctrl          <= '0;
      load_value    <= '0;
      watermark     <= '0;
    end
    else if (wr_en)
    begin
      // Status address is not decoded, so writes to it vanish
      case (wr_addr)
        hello_world_addr: hello_world_q <= wr_data;
        cnt_ctrl_addr:    ctrl.raw      <= wr_data;
        cnt_load_addr:    load_value    <= wr_data[cnt_w-1:0];
        cnt_wmark_addr:   watermark     <= wr_data[cnt_w-1:0];
        default:          ;
      endcase
    end
  end

  // Byte order reversed on read
  assign hello_world_swap = {hello_world_q[7:0],   hello_world_q[15:8],
                             hello_world_q[23:16], hello_world_q[31:24]};

  // LEDs shadow the low half of the hello-world word
  assign led_shadow = hello_world_q[led_w-1:0];

  // Counter status packing
  always_comb
  begin
    status_word                 = '0;
    status_word[cnt_w-1:0]      = cnt;
    status_word[16 +: tick_w]   = tick_cnt;
    status_word[24]             = ge_watermark;
    status_word[25]             = tick;
  end

  // --------------------------------------------------
  // Read multiplexer
  // --------------------------------------------------
  always_comb
  begin
    case (rd_addr)
      hello_world_addr: rd_data = hello_world_swap;
      vled_addr:        rd_data = bus_data_w'(led_status);
      cnt_ctrl_addr:    rd_data = ctrl.raw;
      cnt_load_addr:    rd_data = bus_data_w'(load_value);
      cnt_wmark_addr:   rd_data = bus_data_w'(watermark);
      cnt_status_addr:  rd_data = status_word;
      // Unmapped space reads as zero
      default:          rd_data = '0;
    endcase
  end

endmodule

//--- tick_counter.sv
module tick_counter #(
  parameter int cnt_w  = 16,
  parameter int tick_w = 8
) (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  hello_world_pkg::cnt_ctrl_u ctrl,
  input  logic [cnt_w-1:0]           load_value,
  input  logic [cnt_w-1:0]           watermark,
  output logic [cnt_w-1:0]           cnt,
  output logic [tick_w-1:0]          tick_cnt,
  output logic                       tick,
  output logic                       ge_watermark
);

  logic tick_wrap;
  logic cnt_at_max;

  // --------------------------------------------------
  // Tick divider
  // --------------------------------------------------
  // Divider has reached its terminal value
  assign tick       = (tick_cnt >= ctrl.fields.tick_value);
  assign tick_wrap  = ctrl.fields.enable & tick;
  assign cnt_at_max = (cnt == {cnt_w{1'b1}});

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync || ctrl.fields.clear)
      tick_cnt <= '0;
    else if (tick_wrap)
      tick_cnt <= '0;
    else if (ctrl.fields.enable)
      tick_cnt <= tick_cnt + 1'b1;
  end

  // --------------------------------------------------
  // Main counter
  // --------------------------------------------------
  // Clear beats load, load beats counting
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync || ctrl.fields.clear)
      cnt <= '0;
    else if (ctrl.fields.load)
      cnt <= load_value;
    else if (tick_wrap)
    begin
      // One-shot saturates, free-running wraps
      if (!(ctrl.fields.oneshot && cnt_at_max))
        cnt <= cnt + 1'b1;
    end
  end

  // Watermark compare on the live count
  assign ge_watermark = (cnt >= watermark);

endmodule

//--- vled_out.sv
module vled_out #(
  parameter int led_w = 16
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic [led_w-1:0] led_shadow,
  input  logic [led_w-1:0] vdip,
  output logic [led_w-1:0] led_status,
  output logic [led_w-1:0] vled
);

  logic [led_w-1:0] vdip_q1;
  logic [led_w-1:0] vdip_q2;

  // --------------------------------------------------
  // DIP sync, shadow flop, masked LED output
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vdip_q1    <= '0;
      vdip_q2    <= '0;
      led_status <= '0;
      vled       <= '0;
    end
    else
    begin
      // Two-flop synchronizer for the switch inputs
      vdip_q1    <= vdip;
      vdip_q2    <= vdip_q1;
      // Shadow copy, also readable on the bus
      led_status <= led_shadow;
      // Switches mask the LEDs
      vled       <= led_status & vdip_q2;
    end
  end

endmodule

//--- hello_world_top.sv
module hello_world_top #(
  parameter int led_w  = 16,
  parameter int cnt_w  = 16,
  parameter int tick_w = 8
) (
  input  logic                                   clk_main_a0,
  input  logic                                   rst_main_n_sync,
  // Control bus
  input  logic                                   awvalid,
  input  logic [hello_world_pkg::bus_addr_w-1:0] awaddr,
  output logic                                   awready,
  input  logic                                   wvalid,
  input  logic [hello_world_pkg::bus_data_w-1:0] wdata,
  output logic                                   wready,
  output logic                                   bvalid,
  output logic [1:0]                             bresp,
  input  logic                                   bready,
  input  logic                                   arvalid,
  input  logic [hello_world_pkg::bus_addr_w-1:0] araddr,
  output logic                                   arready,
  output logic                                   rvalid,
  output logic [hello_world_pkg::bus_data_w-1:0] rdata,
  output logic [1:0]                             rresp,
  input  logic                                   rready,
  // Virtual switches and LEDs
  input  logic [led_w-1:0]                       vdip,
  output logic [led_w-1:0]                       vled
);
  import hello_world_pkg::*;

  // Bus slave to register file
  logic                  wr_en;
  logic [bus_addr_w-1:0] wr_addr;
  logic [bus_data_w-1:0] wr_data;
  logic [bus_addr_w-1:0] rd_addr;
  logic [bus_data_w-1:0] rd_data;

  // Register file to counter and back
  cnt_ctrl_u             ctrl;
  logic [cnt_w-1:0]      load_value;
  logic [cnt_w-1:0]      watermark;
  logic [cnt_w-1:0]      cnt;
  logic [tick_w-1:0]     tick_cnt;
  logic                  tick;
  logic                  ge_watermark;

  // Register file to LED stage and back
  logic [led_w-1:0]      led_shadow;
  logic [led_w-1:0]      led_status;

  // --------------------------------------------------
  // Bus front end
  // --------------------------------------------------
  ocl_bus_slave i_ocl_bus_slave (.*);

  // --------------------------------------------------
  // Registers and counter
  // --------------------------------------------------
  hello_world_regs #(
    .cnt_w  (cnt_w),
    .tick_w (tick_w),
    .led_w  (led_w)
  ) i_hello_world_regs (.*);

  tick_counter #(
    .cnt_w  (cnt_w),
    .tick_w (tick_w)
  ) i_tick_counter (.*);

  // --------------------------------------------------
  // LED output stage
  // --------------------------------------------------
  vled_out #(
    .led_w (led_w)
  ) i_vled_out (.*);

endmodule

//--- hello_world_tb.sv
module hello_world_tb;
  import hello_world_pkg::*;

  localparam int led_w  = 16;
  localparam int cnt_w  = 16;
  localparam int tick_w = 8;
  // Limit sits well above the roughly 1500 cycles the tests need
  localparam int timeout_cycles = 4000;

  logic                  clk_main_a0 = 1'b0;
  logic                  rst_main_n_sync;
  logic                  awvalid;
  logic [bus_addr_w-1:0] awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [bus_data_w-1:0] wdata;
  logic                  wready;
  logic                  bvalid;
  logic [1:0]            bresp;
  logic                  bready;
  logic                  arvalid;
  logic [bus_addr_w-1:0] araddr;
  logic                  arready;
  logic                  rvalid;
  logic [bus_data_w-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rready;
  logic [led_w-1:0]      vdip;
  logic [led_w-1:0]      vled;

  logic [31:0]           lfsr_state;
  int                    cycle_count = 0;
  int                    checks;
  int                    errors;

  // Reference model of the writable registers
  logic [bus_data_w-1:0] model_hello;
  cnt_ctrl_u             model_ctrl;
  logic [cnt_w-1:0]      model_load;
  logic [cnt_w-1:0]      model_wmark;

  hello_world_top #(
    .led_w  (led_w),
    .cnt_w  (cnt_w),
    .tick_w (tick_w)
  ) i_hello_world_top (.*);

  // --------------------------------------------------
  // Clock and watchdog
  // --------------------------------------------------
  always #50 clk_main_a0 = ~clk_main_a0;

  always @(posedge clk_main_a0)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("Timeout after %0d cycles, a bus handshake never completed", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    logic        fb;
    int          i;
    value = '0;
    for (i = 0; i < width; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  // Expected hello-world read value
  function automatic logic [31:0] byte_swap(input logic [31:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic word_check(input string name, input logic [bus_data_w-1:0] got,
                            input logic [bus_data_w-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic led_check(input string name, input logic [led_w-1:0] got,
                           input logic [led_w-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic ctrl_check(input string name, input cnt_ctrl_u got, input cnt_ctrl_u exp);
    checks++;
    if (got.raw !== exp.raw)
    begin
      errors++;
      $display("FAILED %0t: %s = %h, expected %h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic cnt_check(input string name, input logic [cnt_w-1:0] got,
                           input logic [cnt_w-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic resp_check(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic bit_check(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic flag_error(input string what);
    errors++;
    $display("ERROR %0t: %s", $time, what);
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%s: %0d errors", name, errors - errors_before);
  endtask

  // --------------------------------------------------
  // Bus master
  // --------------------------------------------------
  // Handshakes sampled on the falling edge and transferred on the next rising edge
  task automatic bus_write(input logic [bus_addr_w-1:0] addr,
                           input logic [bus_data_w-1:0] data);
    @(posedge clk_main_a0);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    @(negedge clk_main_a0);
    while (!awready)
      @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    awvalid <= 1'b0;
    @(negedge clk_main_a0);
    while (!wready)
      @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    wvalid <= 1'b0;
    @(negedge clk_main_a0);
    while (!bvalid)
      @(negedge clk_main_a0);
    resp_check("bresp", bresp, resp_okay);
    // Response taken on this edge since bready is high
    @(posedge clk_main_a0);
  endtask

  task automatic bus_read(input logic [bus_addr_w-1:0] addr, input int stall,
                          output logic [bus_data_w-1:0] data);
    int n;
    @(posedge clk_main_a0);
    arvalid <= 1'b1;
    araddr  <= addr;
    if (stall > 0)
      rready <= 1'b0;
    @(negedge clk_main_a0);
    while (!arready)
      @(negedge clk_main_a0);
    @(posedge clk_main_a0);
    arvalid <= 1'b0;
    @(negedge clk_main_a0);
    while (!rvalid)
      @(negedge clk_main_a0);
    data = rdata;
    resp_check("rresp", rresp, resp_okay);
    // Slave holds its read data while the master stalls
    for (n = 0; n < stall; n++)
    begin
      @(negedge clk_main_a0);
      word_check("rdata while stalled", rdata, data);
      if (!rvalid || arready)
        flag_error("rvalid dropped or arready rose before the read data was taken");
    end
    if (stall > 0)
    begin
      @(posedge clk_main_a0);
      rready <= 1'b1;
    end
    @(posedge clk_main_a0);
  endtask

  // Builds a control word field by field and keeps the model in step
  task automatic set_ctrl(input logic enable, input logic load, input logic clear,
                          input logic oneshot, input logic [7:0] tick_value);
    model_ctrl.raw                = '0;
    model_ctrl.fields.enable      = enable;
    model_ctrl.fields.load        = load;
    model_ctrl.fields.clear       = clear;
    model_ctrl.fields.oneshot     = oneshot;
    model_ctrl.fields.tick_value  = tick_value;
    bus_write(cnt_ctrl_addr, model_ctrl.raw);
  endtask

  // Status fields must agree with each other and the model
  task automatic status_consistency(input logic [bus_data_w-1:0] word);
    bit_check("ge_watermark", word[24], word[cnt_w-1:0] >= model_wmark);
    bit_check("tick", word[25], word[23:16] == model_ctrl.fields.tick_value);
    if (word[23:16] > model_ctrl.fields.tick_value)
      flag_error("tick_cnt went past tick_value");
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    cnt_ctrl_u             c;
    logic [bus_data_w-1:0] rd;
    logic [bus_data_w-1:0] rd2;
    logic [bus_addr_w-1:0] addr;
    logic [led_w-1:0]      dip;
    logic [7:0]            tv;
    int                    base;
    int                    k;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b1;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b1;
    vdip            = '0;
    lfsr_state      = 32'ha986;
    checks          = 0;
    errors          = 0;
    model_hello     = '0;
    model_ctrl.raw  = '0;
    model_load      = '0;
    model_wmark     = '0;
    repeat (2) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(negedge clk_main_a0);
    if (!awready || !arready || bvalid || rvalid || vled != '0)
      flag_error("bus or LED outputs not at their reset values");

    // Hello-world write and byte-swapped read-back
    base = errors;
    for (k = 0; k < 20; k++)
    begin
      model_hello = random_bits(32);
      bus_write(hello_world_addr, model_hello);
      bus_read(hello_world_addr, 0, rd);
      word_check("hello_world", rd, byte_swap(model_hello));
    end
    report_test("test 1 hello-world read-back", base);

    // LED shadow masked by the DIP switches
    base = errors;
    for (k = 0; k < 8; k++)
    begin
      model_hello = random_bits(32);
      dip         = led_w'(random_bits(led_w));
      bus_write(hello_world_addr, model_hello);
      @(posedge clk_main_a0);
      vdip <= dip;
      repeat (5) @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      led_check("vled", vled, model_hello[led_w-1:0] & dip);
      bus_read(vled_addr, 0, rd);
      word_check("led_status", rd, bus_data_w'(model_hello[led_w-1:0]));
    end
    report_test("test 2 virtual LEDs", base);

    // Counter registers read back and unmapped space reads zero
    base = errors;
    for (k = 0; k < 10; k++)
    begin
      model_ctrl.raw = random_bits(32);
      model_load     = cnt_w'(random_bits(cnt_w));
      model_wmark    = cnt_w'(random_bits(cnt_w));
      bus_write(cnt_ctrl_addr, model_ctrl.raw);
      bus_write(cnt_load_addr, bus_data_w'(model_load));
      bus_write(cnt_wmark_addr, bus_data_w'(model_wmark));
      bus_read(cnt_ctrl_addr, 0, rd);
      c.raw = rd;
      ctrl_check("ctrl", c, model_ctrl);
      bus_read(cnt_load_addr, 0, rd);
      word_check("load_value", rd, bus_data_w'(model_load));
      bus_read(cnt_wmark_addr, 0, rd);
      word_check("watermark", rd, bus_data_w'(model_wmark));
      addr = random_bits(32);
      // Steer away from the register window
      if (addr >= hello_world_addr && addr <= cnt_status_addr + 32'd3)
        addr = cnt_status_addr + 32'd4;
      bus_read(addr, 0, rd);
      word_check("unmapped read", rd, 32'h0);
    end
    report_test("test 3 control registers", base);

    // Clear, load, hold and count
    base = errors;
    model_wmark = cnt_w'(random_bits(cnt_w));
    bus_write(cnt_wmark_addr, bus_data_w'(model_wmark));
    set_ctrl(1'b0, 1'b0, 1'b1, 1'b0, 8'h00);
    bus_read(cnt_status_addr, 0, rd);
    status_consistency(rd);
    cnt_check("cnt after clear", rd[cnt_w-1:0], 16'h0000);
    model_load = cnt_w'(random_bits(cnt_w));
    bus_write(cnt_load_addr, bus_data_w'(model_load));
    set_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 8'h00);
    bus_read(cnt_status_addr, 0, rd);
    status_consistency(rd);
    cnt_check("cnt after load", rd[cnt_w-1:0], model_load);
    set_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 8'h00);
    bus_read(cnt_status_addr, 0, rd);
    bus_read(cnt_status_addr, 0, rd2);
    status_consistency(rd);
    status_consistency(rd2);
    word_check("status while disabled", rd2, rd);
    // Small divider so the count moves between reads
    tv = 8'(random_bits(3));
    set_ctrl(1'b1, 1'b0, 1'b0, 1'b0, tv);
    for (k = 0; k < 6; k++)
    begin
      bus_read(cnt_status_addr, 0, rd);
      status_consistency(rd);
    end
    set_ctrl(1'b0, 1'b0, 1'b0, 1'b0, tv);
    bus_read(cnt_status_addr, 0, rd);
    bus_read(cnt_status_addr, 0, rd2);
    status_consistency(rd);
    status_consistency(rd2);
    word_check("status after stop", rd2, rd);
    report_test("test 4 counter control", base);

    // One-shot saturation against free-running wrap with stalled reads
    base = errors;
    model_load = 16'hFFF0;
    bus_write(cnt_load_addr, 32'h0000_FFF0);
    set_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 8'h00);
    set_ctrl(1'b1, 1'b0, 1'b0, 1'b1, 8'h00);
    repeat (100) @(posedge clk_main_a0);
    set_ctrl(1'b0, 1'b0, 1'b0, 1'b1, 8'h00);
    bus_read(cnt_status_addr, 1 + int'(random_bits(3)), rd);
    cnt_check("cnt one-shot", rd[cnt_w-1:0], 16'hFFFF);
    set_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 8'h00);
    set_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
    repeat (100) @(posedge clk_main_a0);
    set_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 8'h00);
    bus_read(cnt_status_addr, 1 + int'(random_bits(3)), rd);
    if (rd[cnt_w-1:0] >= 16'hFFF0)
      flag_error("cnt did not wrap with one-shot off");
    report_test("test 5 one-shot", base);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- hello_world.f
hello_world_pkg.sv
ocl_bus_slave.sv
hello_world_regs.sv
tick_counter.sv
vled_out.sv
hello_world_top.sv
hello_world_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module hello_world_tb -f hello_world.f -o hello_world_sim \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/hello_world_sim)"
echo "$sim_out"
grep -qx "TEST PASS" <<< "$sim_out" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
